// File: rtl/l1_cache_pkg.sv
//////////////////////////////
// bus word types, controller
// states, byte-lane helpers
//////////////////////////////
`default_nettype none

package l1_cache_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [3:0] byte_en_t;

    typedef enum logic [2:0] {
        INIT,
        HIT,
        FETCH,
        WB,
        FLUSH
    } cache_state_t;

    // zeros mark the lanes a write replaces
    // single lanes and halves are decoded, anything else is a full word
    function automatic word_t lane_mask(byte_en_t be);
        case (be)
            4'b0001: return 32'hFFFF_FF00;
            4'b0010: return 32'hFFFF_00FF;
            4'b0100: return 32'hFF00_FFFF;
            4'b1000: return 32'h00FF_FFFF;
            4'b0011: return 32'hFFFF_0000;
            4'b1100: return 32'h0000_FFFF;
            default: return 32'h0000_0000;
        endcase
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, byte_en_t be);
        word_t keep;
        keep = lane_mask(be);
        return (old_w & keep) | (new_w & ~keep);
    endfunction

    // disabled lanes go out as zero
    function automatic word_t align_wdata(word_t w, byte_en_t be);
        return w & ~lane_mask(be);
    endfunction

endpackage

`default_nettype wire

// File: rtl/cache_array.sv
//////////////////////////////
// tag and data storage,
// one packed image per set
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cache_array #(
    parameter int CACHE_SIZE = 512,
    parameter int BLOCK_SIZE = 2,
    parameter int ASSOC      = 2,
    localparam int N_SETS    = CACHE_SIZE / (4 * BLOCK_SIZE * ASSOC),
    localparam int SET_W     = $clog2(N_SETS) + (N_SETS == 1),
    localparam int TAG_W     = 32 - SET_W - ($clog2(BLOCK_SIZE) + (BLOCK_SIZE == 1)) - 2,
    localparam int FRAME_W   = 32 * BLOCK_SIZE + TAG_W + 2,
    localparam int SET_IMG_W = FRAME_W * ASSOC
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [SET_W-1:0]     sel,
    input  logic                 wen,
    input  logic [SET_IMG_W-1:0] wval,
    input  logic [SET_IMG_W-1:0] wmask,
    output logic [SET_IMG_W-1:0] rval
);

    logic [SET_IMG_W-1:0] mem [N_SETS];

    // a 0 in wmask takes the bit from wval, a 1 keeps the stored bit
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < N_SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            mem[sel] <= (mem[sel] & wmask) | (wval & ~wmask);
        end
    end

    assign rval = mem[sel];

endmodule

`default_nettype wire

// File: rtl/way_select.sv
//////////////////////////////
// tag compare, hit data and
// NRU victim choice per set
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module way_select #(
    parameter int CACHE_SIZE = 512,
    parameter int BLOCK_SIZE = 2,
    parameter int ASSOC      = 2,
    localparam int N_SETS    = CACHE_SIZE / (4 * BLOCK_SIZE * ASSOC),
    localparam int SET_W     = $clog2(N_SETS) + (N_SETS == 1),
    localparam int WAY_W     = $clog2(ASSOC) + (ASSOC == 1),
    localparam int TAG_W     = 32 - SET_W - ($clog2(BLOCK_SIZE) + (BLOCK_SIZE == 1)) - 2,
    localparam int DATA_W    = 32 * BLOCK_SIZE,
    localparam int DIRTY_B   = DATA_W + TAG_W,
    localparam int VALID_B   = DIRTY_B + 1,
    localparam int FRAME_W   = VALID_B + 1,
    localparam int SET_IMG_W = FRAME_W * ASSOC
) (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic [SET_IMG_W-1:0]                    set_img,
    input  logic [TAG_W-1:0]                        req_tag,
    input  logic [SET_W-1:0]                        set_idx,
    input  logic                                    touch,
    input  logic [WAY_W-1:0]                        touch_way,
    output logic                                    hit,
    output logic [WAY_W-1:0]                        hit_way,
    output l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    hit_data,
    output logic [WAY_W-1:0]                        victim_way,
    output logic                                    victim_dirty,
    output logic [TAG_W-1:0]                        victim_tag
);

    // frame layout, msb first: valid, dirty, tag, data words
    logic [N_SETS-1:0][WAY_W-1:0] last_used;

    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        hit_data = '0;
        for (int i = 0; i < ASSOC; i++) begin
            if (set_img[i*FRAME_W + VALID_B] &&
                set_img[i*FRAME_W + DATA_W +: TAG_W] == req_tag) begin
                hit      = 1'b1;
                hit_way  = WAY_W'(i);
                hit_data = set_img[i*FRAME_W +: DATA_W];
            end
        end
    end

    // next way after the last one used, wrapping
    always_comb begin
        if (ASSOC == 1 || last_used[set_idx] == WAY_W'(ASSOC - 1)) begin
            victim_way = '0;
        end else begin
            victim_way = last_used[set_idx] + 1'b1;
        end
    end

    assign victim_dirty = set_img[victim_way*FRAME_W + DIRTY_B];
    assign victim_tag   = set_img[victim_way*FRAME_W + DATA_W +: TAG_W];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_used <= '0;
        end else if (touch) begin
            last_used[set_idx] <= touch_way;
        end
    end

endmodule

`default_nettype wire

// File: rtl/flush_counter.sv
//////////////////////////////
// frame walker for clear
// and flush
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module flush_counter #(
    parameter int CACHE_SIZE = 512,
    parameter int BLOCK_SIZE = 2,
    parameter int ASSOC      = 2,
    localparam int N_SETS    = CACHE_SIZE / (4 * BLOCK_SIZE * ASSOC),
    localparam int SET_W     = $clog2(N_SETS) + (N_SETS == 1),
    localparam int WAY_W     = $clog2(ASSOC) + (ASSOC == 1)
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             step,
    input  logic             restart,
    output logic [SET_W-1:0] set_num,
    output logic [WAY_W-1:0] frame_num,
    output logic             finish
);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            set_num   <= '0;
            frame_num <= '0;
            finish    <= 1'b0;
        end else if (restart) begin
            set_num   <= '0;
            frame_num <= '0;
            finish    <= 1'b0;
        end else if (step) begin
            if (frame_num == WAY_W'(ASSOC - 1)) begin
                frame_num <= '0;
                // last frame of last set, wrap and flag
                if (set_num == SET_W'(N_SETS - 1)) begin
                    set_num <= '0;
                    finish  <= 1'b1;
                end else begin
                    set_num <= set_num + 1'b1;
                end
            end else begin
                frame_num <= frame_num + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/cache_ctrl.sv
//////////////////////////////
// cache FSM, processor and
// memory bus, array writes
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter int CACHE_SIZE                    = 512,
    parameter int BLOCK_SIZE                    = 2,
    parameter int ASSOC                         = 2,
    parameter l1_cache_pkg::word_t NONCACHE_START_ADDR = 32'hF000_0000,
    localparam int N_SETS    = CACHE_SIZE / (4 * BLOCK_SIZE * ASSOC),
    localparam int SET_W     = $clog2(N_SETS) + (N_SETS == 1),
    localparam int WAY_W     = $clog2(ASSOC) + (ASSOC == 1),
    localparam int BLK_W     = $clog2(BLOCK_SIZE) + (BLOCK_SIZE == 1),
    localparam int TAG_W     = 32 - SET_W - BLK_W - 2,
    localparam int DATA_W    = 32 * BLOCK_SIZE,
    localparam int DIRTY_B   = DATA_W + TAG_W,
    localparam int VALID_B   = DIRTY_B + 1,
    localparam int FRAME_W   = VALID_B + 1,
    localparam int SET_IMG_W = FRAME_W * ASSOC
) (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic                                    flush,
    input  logic                                    ren,
    input  logic                                    wen,
    input  l1_cache_pkg::word_t                     addr,
    input  l1_cache_pkg::word_t                     wdata,
    input  l1_cache_pkg::byte_en_t                  byte_en,
    output l1_cache_pkg::word_t                     rdata,
    output logic                                    busy,
    output logic                                    mem_ren,
    output logic                                    mem_wen,
    output l1_cache_pkg::word_t                     mem_addr,
    output l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    mem_wdata,
    output l1_cache_pkg::byte_en_t                  mem_byte_en,
    input  l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    mem_rdata,
    input  logic                                    mem_busy,
    input  logic [SET_IMG_W-1:0]                    set_img,
    input  logic                                    hit,
    input  logic [WAY_W-1:0]                        hit_way,
    input  l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    hit_data,
    input  logic [WAY_W-1:0]                        victim_way,
    input  logic                                    victim_dirty,
    input  logic [TAG_W-1:0]                        victim_tag,
    output logic [SET_W-1:0]                        arr_sel,
    output logic                                    arr_wen,
    output logic [SET_IMG_W-1:0]                    arr_wval,
    output logic [SET_IMG_W-1:0]                    arr_wmask,
    output logic [TAG_W-1:0]                        req_tag,
    output logic                                    touch,
    output logic [WAY_W-1:0]                        touch_way,
    input  logic [SET_W-1:0]                        flush_set,
    input  logic [WAY_W-1:0]                        flush_frame,
    input  logic                                    flush_finish,
    output logic                                    flush_step,
    output logic                                    flush_restart,
    output logic                                    flush_done,
    output logic                                    cache_miss
);

    typedef union packed {
        l1_cache_pkg::word_t word;
        struct packed {
            logic [TAG_W-1:0] tag;
            logic [SET_W-1:0] set;
            logic [BLK_W-1:0] blk;
            logic [1:0]       byte_off;
        } f;
    } req_addr_t;

    l1_cache_pkg::cache_state_t state, next_state;
    req_addr_t req;
    logic flush_req;
    logic access;
    logic pass_through;
    logic flush_dirty;
    int unsigned hb;
    int unsigned vb;
    int unsigned fb;
    l1_cache_pkg::word_t [BLOCK_SIZE-1:0] fill;

    function automatic l1_cache_pkg::word_t block_addr(logic [TAG_W-1:0] tag,
                                                       logic [SET_W-1:0] set);
        req_addr_t a;
        a.f.tag      = tag;
        a.f.set      = set;
        a.f.blk      = '0;
        a.f.byte_off = 2'b00;
        return a.word;
    endfunction

    assign req          = req_addr_t'(addr);
    assign req_tag      = req.f.tag;
    assign access       = ren || wen;
    assign pass_through = addr >= NONCACHE_START_ADDR;
    assign touch_way    = hit_way;

    // bit offsets of the hit, victim and flush frames in the set image
    assign hb = hit_way * FRAME_W;
    assign vb = victim_way * FRAME_W;
    assign fb = flush_frame * FRAME_W;
    assign flush_dirty = set_img[fb + VALID_B] && set_img[fb + DIRTY_B];

    assign arr_sel = (state == l1_cache_pkg::INIT || state == l1_cache_pkg::FLUSH)
                   ? flush_set : req.f.set;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= l1_cache_pkg::INIT;
            flush_req <= 1'b0;
        end else begin
            state <= next_state;
            if (flush_done) begin
                flush_req <= 1'b0;
            end else if (flush) begin
                flush_req <= 1'b1;
            end
        end
    end

    always_comb begin
        next_state    = state;
        busy          = 1'b1;
        rdata         = '0;
        mem_ren       = 1'b0;
        mem_wen       = 1'b0;
        mem_addr      = '0;
        mem_wdata     = '0;
        mem_byte_en   = 4'hF;
        arr_wen       = 1'b0;
        arr_wval      = '0;
        arr_wmask     = '1;
        touch         = 1'b0;
        flush_step    = 1'b0;
        flush_restart = 1'b0;
        flush_done    = 1'b0;
        cache_miss    = 1'b0;
        fill          = mem_rdata;

        case (state)
            l1_cache_pkg::INIT: begin
                // one frame invalidated per cycle
                arr_wen = 1'b1;
                arr_wmask[fb +: FRAME_W] = '0;
                flush_step = 1'b1;
                if (flush_finish) begin
                    flush_restart = 1'b1;
                    next_state    = l1_cache_pkg::HIT;
                end
            end
            l1_cache_pkg::HIT: begin
                if (flush || flush_req) begin
                    next_state = l1_cache_pkg::FLUSH;
                end else if (access && pass_through) begin
                    // uncached word rides in word 0 of the block
                    mem_ren      = ren;
                    mem_wen      = wen;
                    mem_addr     = addr;
                    mem_byte_en  = byte_en;
                    mem_wdata[0] = l1_cache_pkg::align_wdata(wdata, byte_en);
                    busy         = mem_busy;
                    rdata        = mem_rdata[0];
                end else if (access && hit) begin
                    busy  = 1'b0;
                    touch = 1'b1;
                    if (ren) begin
                        rdata = hit_data[req.f.blk];
                    end else begin
                        arr_wen = 1'b1;
                        arr_wval[hb + req.f.blk*32 +: 32]  = wdata;
                        arr_wmask[hb + req.f.blk*32 +: 32] = l1_cache_pkg::lane_mask(byte_en);
                        arr_wval[hb + DIRTY_B]  = 1'b1;
                        arr_wmask[hb + DIRTY_B] = 1'b0;
                    end
                end else if (access) begin
                    next_state = victim_dirty ? l1_cache_pkg::WB : l1_cache_pkg::FETCH;
                end
            end
            l1_cache_pkg::WB: begin
                mem_wen   = 1'b1;
                mem_addr  = block_addr(victim_tag, req.f.set);
                mem_wdata = set_img[vb +: DATA_W];
                if (!mem_busy) begin
                    // drop valid and dirty of the victim
                    arr_wen = 1'b1;
                    arr_wmask[vb + DIRTY_B +: 2] = 2'b00;
                    next_state = l1_cache_pkg::FETCH;
                end
            end
            l1_cache_pkg::FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = block_addr(req.f.tag, req.f.set);
                if (!mem_busy) begin
                    if (wen) begin
                        fill[req.f.blk] = l1_cache_pkg::merge_bytes(mem_rdata[req.f.blk],
                                                                    wdata, byte_en);
                    end
                    arr_wen = 1'b1;
                    arr_wval[vb +: FRAME_W]  = {1'b1, wen, req.f.tag, fill};
                    arr_wmask[vb +: FRAME_W] = '0;
                    cache_miss = 1'b1;
                    next_state = l1_cache_pkg::HIT;
                end
            end
            l1_cache_pkg::FLUSH: begin
                if (flush_finish) begin
                    flush_done    = 1'b1;
                    flush_restart = 1'b1;
                    next_state    = l1_cache_pkg::HIT;
                end else begin
                    if (flush_dirty) begin
                        mem_wen   = 1'b1;
                        mem_addr  = block_addr(set_img[fb + DATA_W +: TAG_W], flush_set);
                        mem_wdata = set_img[fb +: DATA_W];
                    end
                    // clean frames move on at once, dirty ones after the write
                    if (!flush_dirty || !mem_busy) begin
                        arr_wen = 1'b1;
                        arr_wmask[fb +: FRAME_W] = '0;
                        flush_step = 1'b1;
                    end
                end
            end
            default: begin
                next_state = l1_cache_pkg::INIT;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/l1_cache.sv
//////////////////////////////
// L1 data cache top level
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module l1_cache #(
    parameter int CACHE_SIZE                           = 512,
    parameter int BLOCK_SIZE                           = 2,
    parameter int ASSOC                                = 2,
    parameter l1_cache_pkg::word_t NONCACHE_START_ADDR = 32'hF000_0000
) (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic                                    flush,
    output logic                                    flush_done,
    output logic                                    cache_miss,
    input  logic                                    ren,
    input  logic                                    wen,
    input  l1_cache_pkg::word_t                     addr,
    input  l1_cache_pkg::word_t                     wdata,
    input  l1_cache_pkg::byte_en_t                  byte_en,
    output l1_cache_pkg::word_t                     rdata,
    output logic                                    busy,
    output logic                                    mem_ren,
    output logic                                    mem_wen,
    output l1_cache_pkg::word_t                     mem_addr,
    output l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    mem_wdata,
    output l1_cache_pkg::byte_en_t                  mem_byte_en,
    input  l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    mem_rdata,
    input  logic                                    mem_busy
);

    localparam int N_SETS    = CACHE_SIZE / (4 * BLOCK_SIZE * ASSOC);
    localparam int SET_W     = $clog2(N_SETS) + (N_SETS == 1);
    localparam int WAY_W     = $clog2(ASSOC) + (ASSOC == 1);
    localparam int TAG_W     = 32 - SET_W - ($clog2(BLOCK_SIZE) + (BLOCK_SIZE == 1)) - 2;
    localparam int SET_IMG_W = (32 * BLOCK_SIZE + TAG_W + 2) * ASSOC;

    logic [SET_IMG_W-1:0] set_img;
    logic [SET_IMG_W-1:0] arr_wval;
    logic [SET_IMG_W-1:0] arr_wmask;
    logic [SET_W-1:0] arr_sel;
    logic arr_wen;
    logic [TAG_W-1:0] req_tag;
    logic touch;
    logic [WAY_W-1:0] touch_way;
    logic hit;
    logic [WAY_W-1:0] hit_way;
    l1_cache_pkg::word_t [BLOCK_SIZE-1:0] hit_data;
    logic [WAY_W-1:0] victim_way;
    logic victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    logic [SET_W-1:0] flush_set;
    logic [WAY_W-1:0] flush_frame;
    logic flush_finish;
    logic flush_step;
    logic flush_restart;

    cache_array #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC)) u_array (
        .CLK(CLK), .nRST(nRST), .sel(arr_sel), .wen(arr_wen),
        .wval(arr_wval), .wmask(arr_wmask), .rval(set_img)
    );

    way_select #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC)) u_ways (
        .CLK(CLK), .nRST(nRST), .set_img(set_img), .req_tag(req_tag), .set_idx(arr_sel),
        .touch(touch), .touch_way(touch_way), .hit(hit), .hit_way(hit_way),
        .hit_data(hit_data), .victim_way(victim_way), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag)
    );

    flush_counter #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC)) u_fcnt (
        .CLK(CLK), .nRST(nRST), .step(flush_step), .restart(flush_restart),
        .set_num(flush_set), .frame_num(flush_frame), .finish(flush_finish)
    );

    cache_ctrl #(
        .CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC),
        .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
    ) u_ctrl (
        .CLK(CLK), .nRST(nRST), .flush(flush),
        .ren(ren), .wen(wen), .addr(addr), .wdata(wdata), .byte_en(byte_en),
        .rdata(rdata), .busy(busy),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_byte_en(mem_byte_en), .mem_rdata(mem_rdata), .mem_busy(mem_busy),
        .set_img(set_img), .hit(hit), .hit_way(hit_way), .hit_data(hit_data),
        .victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .arr_sel(arr_sel), .arr_wen(arr_wen), .arr_wval(arr_wval), .arr_wmask(arr_wmask),
        .req_tag(req_tag), .touch(touch), .touch_way(touch_way),
        .flush_set(flush_set), .flush_frame(flush_frame), .flush_finish(flush_finish),
        .flush_step(flush_step), .flush_restart(flush_restart),
        .flush_done(flush_done), .cache_miss(cache_miss)
    );

endmodule

`default_nettype wire

// File: test/tb_l1_cache.sv
//////////////////////////////
// cache testbench with LFSR
// stimulus, memory responder
// and reference model
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache;

    localparam int BLOCK_SIZE     = 2;
    localparam int CLEAR_CYCLES   = 512 / (4 * BLOCK_SIZE);
    localparam int N_RAND         = 600;
    localparam int N_WORDS        = 128;
    localparam int N_OPS          = 1 + 2 * N_RAND + N_WORDS + 8 * CLEAR_CYCLES;
    localparam int TIMEOUT_CYCLES = (N_OPS + CLEAR_CYCLES) * 40;
    localparam l1_cache_pkg::word_t PASS_BASE = 32'hF000_0000;
    // single lanes, halves and full words only
    localparam l1_cache_pkg::byte_en_t BE_TABLE [8] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111, 4'b1111
    };

    logic CLK = 1'b0;
    logic nRST, flush, ren, wen;
    l1_cache_pkg::word_t addr, wdata, rdata;
    l1_cache_pkg::byte_en_t byte_en;
    logic busy, flush_done, cache_miss;
    logic mem_ren, mem_wen;
    l1_cache_pkg::word_t mem_addr;
    l1_cache_pkg::word_t [BLOCK_SIZE-1:0] mem_wdata;
    l1_cache_pkg::byte_en_t mem_byte_en;
    l1_cache_pkg::word_t [BLOCK_SIZE-1:0] mem_rdata = '0;
    logic mem_busy = 1'b1;

    // cacheable words sit low and uncached words start at index 1024
    l1_cache_pkg::word_t mem_word [2048];
    l1_cache_pkg::word_t ref_mem [2048];
    logic [15:0] stim_lfsr = 16'd31460;
    logic [15:0] resp_lfsr = 16'd31460;
    logic started = 1'b0;
    logic [1:0] wait_left = 2'd0;
    l1_cache_pkg::word_t req_addr = '0;

    l1_cache u_dut (
        .CLK(CLK), .nRST(nRST), .flush(flush), .flush_done(flush_done),
        .cache_miss(cache_miss), .ren(ren), .wen(wen), .addr(addr), .wdata(wdata),
        .byte_en(byte_en), .rdata(rdata), .busy(busy), .mem_ren(mem_ren),
        .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_byte_en(mem_byte_en), .mem_rdata(mem_rdata), .mem_busy(mem_busy)
    );

    always #5 CLK = ~CLK;

    // galois LFSR stepped once per bit taken
    function automatic l1_cache_pkg::word_t take_bits(inout logic [15:0] st, input int n);
        l1_cache_pkg::word_t v;
        logic lsb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lsb = st[0];
            st = st >> 1;
            if (lsb) st = st ^ 16'hB400;
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    function automatic logic [10:0] mem_index(l1_cache_pkg::word_t a);
        return {a[31], a[11:2]};
    endfunction

    function automatic l1_cache_pkg::word_t fill_word(logic [10:0] i);
        return (32'h9E37_79B1 * {21'h0, i}) ^ {i, 21'h0};
    endfunction

    // tag in [11:8], set in [4:3], word in [2]
    function automatic l1_cache_pkg::word_t pool_addr(logic [6:0] k);
        return {20'h0, k[6:3], 3'b000, k[2:0], 2'b00};
    endfunction

    function automatic l1_cache_pkg::word_t apply_lanes(l1_cache_pkg::word_t old_w,
            l1_cache_pkg::word_t new_w, l1_cache_pkg::byte_en_t be);
        l1_cache_pkg::word_t m;
        m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~m) | (new_w & m);
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input l1_cache_pkg::word_t got,
                               input l1_cache_pkg::word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic do_op(input logic is_wr, input l1_cache_pkg::word_t a,
                         input l1_cache_pkg::word_t d, input l1_cache_pkg::byte_en_t be,
                         output logic missed, output int cyc);
        logic [10:0] idx;
        idx = mem_index(a);
        missed = 1'b0;
        cyc = 0;
        @(negedge CLK);
        ren = !is_wr;
        wen = is_wr;
        addr = a;
        wdata = d;
        byte_en = be;
        // held until busy is seen low at a rising edge
        do begin
            @(posedge CLK);
            cyc++;
            missed |= cache_miss;
        end while (busy);
        if (is_wr) begin
            ref_mem[idx] = apply_lanes(ref_mem[idx], d, be);
        end else begin
            check_value("rdata", rdata, ref_mem[idx]);
        end
    endtask

    task automatic random_op();
        logic is_wr, missed;
        int cyc;
        l1_cache_pkg::word_t a, d;
        l1_cache_pkg::byte_en_t be;
        is_wr = 1'(take_bits(stim_lfsr, 1));
        // one access in eight goes to the uncached window
        if (take_bits(stim_lfsr, 3) == 0) begin
            a = {28'hF00_0000, 2'(take_bits(stim_lfsr, 2)), 2'b00};
        end else begin
            a = pool_addr(7'(take_bits(stim_lfsr, 7)));
        end
        d = take_bits(stim_lfsr, 32);
        be = BE_TABLE[3'(take_bits(stim_lfsr, 3))];
        do_op(is_wr, a, d, be, missed, cyc);
        // a repeated read has to hit
        if (!is_wr && a < PASS_BASE && take_bits(stim_lfsr, 1) == 1) begin
            do_op(1'b0, a, '0, be, missed, cyc);
            check_value("cache_miss", {31'h0, missed}, 32'h0);
        end
    endtask

    task automatic run_flush();
        logic [10:0] idx;
        @(negedge CLK);
        ren = 1'b0;
        wen = 1'b0;
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        do @(posedge CLK); while (!flush_done);
        repeat (8) begin
            @(posedge CLK);
            if (flush_done) fail_now("flush_done pulsed more than once");
        end
        for (int k = 0; k < N_WORDS; k++) begin
            idx = mem_index(pool_addr(7'(k)));
            check_value("mem_word", mem_word[idx], ref_mem[idx]);
        end
    endtask

    // memory responder holds mem_busy on the first cycle of a request and 0 to 3 more
    always @(posedge CLK) begin
        logic [10:0] idx;
        if (!nRST) begin
            for (int i = 0; i < 2048; i++) mem_word[i] = fill_word(11'(i));
            started = 1'b0;
        end else if (mem_ren || mem_wen) begin
            if (!started) begin
                started = 1'b1;
                req_addr = mem_addr;
                wait_left = 2'(take_bits(resp_lfsr, 2));
            end else begin
                check_value("mem_addr", mem_addr, req_addr);
                if (!mem_busy) begin
                    started = 1'b0;
                    if (mem_wen && req_addr >= PASS_BASE) begin
                        idx = mem_index(req_addr);
                        check_value("mem_addr", mem_addr, addr);
                        check_value("mem_byte_en", {28'h0, mem_byte_en}, {28'h0, byte_en});
                        check_value("mem_wdata", mem_wdata[0], apply_lanes('0, wdata, byte_en));
                        mem_word[idx] = apply_lanes(mem_word[idx], mem_wdata[0], mem_byte_en);
                    end else if (mem_wen) begin
                        for (int w = 0; w < BLOCK_SIZE; w++) begin
                            mem_word[mem_index(req_addr + 32'(4 * w))] = mem_wdata[w];
                        end
                    end
                end else if (wait_left != 2'd0) begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end else if (started) begin
            fail_now("memory request dropped before mem_busy went low");
        end
    end

    always @(negedge CLK) begin
        if (started && wait_left == 2'd0) begin
            mem_busy = 1'b0;
            for (int w = 0; w < BLOCK_SIZE; w++) begin
                mem_rdata[w] = mem_word[mem_index(req_addr + 32'(4 * w))];
            end
        end else begin
            mem_busy = 1'b1;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 10);
        fail_now("timeout, the run did not finish in time");
    end

    initial begin
        logic missed;
        int cyc;
        nRST = 1'b0;
        flush = 1'b0;
        ren = 1'b0;
        wen = 1'b0;
        addr = '0;
        wdata = '0;
        byte_en = '0;
        for (int i = 0; i < 2048; i++) ref_mem[i] = fill_word(11'(i));
        repeat (3) @(negedge CLK);
        nRST = 1'b1;
        // first read goes in while the clear is still running
        do_op(1'b0, pool_addr(7'd5), '0, 4'hF, missed, cyc);
        if (cyc <= CLEAR_CYCLES) fail_now("busy went low before the reset clear was over");
        // an empty cache makes the first read fetch
        check_value("cache_miss", {31'h0, missed}, 32'h1);
        for (int i = 0; i < N_RAND; i++) begin
            random_op();
            if (i % 200 == 199) run_flush();
        end
        // read back every pool word after the evictions
        for (int k = 0; k < N_WORDS; k++) begin
            do_op(1'b0, pool_addr(7'(k)), '0, 4'hF, missed, cyc);
        end
        run_flush();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/l1_cache_pkg.sv
rtl/cache_array.sv
rtl/way_select.sv
rtl/flush_counter.sv
rtl/cache_ctrl.sv
rtl/l1_cache.sv
test/tb_l1_cache.sv

// File: run.sh
#!/bin/sh
# build the L1 cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f sources.f \
    --top-module tb_l1_cache -o sim_l1_cache

# the log decides pass or fail
./obj_dir/sim_l1_cache > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
    exit 0
fi
exit 1
